//--- dv/csr_tests.txt
# stimulus: ren wen op msk imm adr wdt trap typ epc ev (hex, one line per cycle)
# expected: rdt ill lvl tvec epc
# mscratch read-modify-write
1 1 1 0 00 340 12345678 0 0 00000000 0 00000000 0 3 00000100 00000000
1 1 2 0 00 340 0000f000 0 0 00000000 0 12345678 0 3 00000100 00000000
1 1 3 1 1f 340 00000000 0 0 00000000 0 1234f678 0 3 00000100 00000000
1 1 2 1 05 340 00000000 0 0 00000000 0 1234f660 0 3 00000100 00000000
1 1 1 1 1a 340 00000000 0 0 00000000 0 1234f665 0 3 00000100 00000000
1 1 3 0 00 340 0000000a 0 0 00000000 0 0000001a 0 3 00000100 00000000
1 0 0 0 00 340 00000000 0 0 00000000 0 00000010 0 3 00000100 00000000
# read-only and unimplemented addresses
1 1 1 0 00 c00 00000055 0 0 00000000 0 00000000 1 3 00000100 00000000
1 0 0 0 00 c00 00000000 0 0 00000000 0 00000000 0 3 00000100 00000000
1 0 0 0 00 343 00000000 0 0 00000000 0 00000000 1 3 00000100 00000000
1 1 1 0 00 7b0 00000001 0 0 00000000 0 00000000 1 3 00000100 00000000
# M-level ECALL and EBREAK, mtvec direct and vectored
0 0 0 0 00 000 00000000 1 1 00000200 0 00000000 0 3 00000100 00000000
1 0 0 0 00 342 00000000 0 0 00000000 0 0000000b 0 3 00000100 00000200
1 0 0 0 00 341 00000000 1 2 00000300 0 00000200 0 3 00000100 00000200
1 0 0 0 00 342 00000000 0 0 00000000 0 00000003 0 3 00000100 00000300
0 1 1 0 00 305 00000401 0 0 00000000 0 00000000 0 3 00000100 00000300
1 0 0 0 00 305 00000000 0 0 00000000 0 00000401 0 3 0000040c 00000300
0 1 1 0 00 340 deadbeef 1 1 00000404 0 00000000 0 3 0000040c 00000300
1 0 0 0 00 340 00000000 0 0 00000000 0 00000010 0 3 0000042c 00000404
0 1 1 0 00 305 00000800 0 0 00000000 0 00000000 0 3 0000042c 00000404
# delegation of M-level ECALL to S level
0 1 1 0 00 105 00001001 0 0 00000000 0 00000000 0 3 00000800 00000404
1 1 2 0 00 302 00000800 0 0 00000000 0 00000000 0 3 00000800 00000404
0 0 0 0 00 000 00000000 1 1 00000500 0 00000000 0 3 00000800 00000404
1 0 0 0 00 340 00000000 0 0 00000000 0 00000000 1 1 0000102c 00000500
1 1 1 0 00 340 ffffffff 0 0 00000000 0 00000000 1 1 0000102c 00000500
1 0 0 0 00 141 00000000 0 0 00000000 0 00000500 0 1 0000102c 00000500
1 0 0 0 00 142 00000000 0 0 00000000 0 0000000b 0 1 0000102c 00000500
1 0 0 0 00 c00 00000000 0 0 00000000 0 00000000 0 1 0000102c 00000500
1 0 0 0 00 105 00000000 1 1 00000600 0 00001001 0 1 0000102c 00000500
1 0 0 0 00 342 00000000 0 0 00000000 0 00000009 0 3 00000800 00000600
1 0 0 0 00 340 00000000 0 0 00000000 0 00000010 0 3 00000800 00000600
# counters, events, inhibit and write priority
0 1 1 0 00 323 00000004 0 0 00000000 0 00000000 0 3 00000800 00000600
0 0 0 0 00 000 00000000 0 0 00000000 f 00000000 0 3 00000800 00000600
0 0 0 0 00 000 00000000 0 0 00000000 3 00000000 0 3 00000800 00000600
1 0 0 0 00 b00 00000000 0 0 00000000 1 00000002 0 3 00000800 00000600
1 0 0 0 00 b02 00000000 0 0 00000000 0 00000002 0 3 00000800 00000600
1 0 0 0 00 b03 00000000 0 0 00000000 4 00000001 0 3 00000800 00000600
1 0 0 0 00 c02 00000000 0 0 00000000 0 00000002 0 3 00000800 00000600
0 1 1 0 00 320 00000009 0 0 00000000 0 00000000 0 3 00000800 00000600
0 0 0 0 00 000 00000000 0 0 00000000 f 00000000 0 3 00000800 00000600
1 0 0 0 00 c00 00000000 0 0 00000000 0 00000003 0 3 00000800 00000600
1 0 0 0 00 b02 00000000 0 0 00000000 0 00000003 0 3 00000800 00000600
1 0 0 0 00 b03 00000000 0 0 00000000 0 00000002 0 3 00000800 00000600
1 1 3 1 1f 320 00000000 0 0 00000000 0 00000009 0 3 00000800 00000600
0 1 1 0 00 b00 00000100 0 0 00000000 1 00000000 0 3 00000800 00000600
1 1 1 0 00 b02 00000050 0 0 00000000 3 00000003 0 3 00000800 00000600
1 0 0 0 00 b00 00000000 0 0 00000000 0 00000101 0 3 00000800 00000600
1 0 0 0 00 b02 00000000 0 0 00000000 0 00000050 0 3 00000800 00000600
1 0 0 0 00 b04 00000000 0 0 00000000 f 00000000 0 3 00000800 00000600
1 0 0 0 00 b03 00000000 0 0 00000000 0 00000003 0 3 00000800 00000600

//--- list.f
+incdir+common
common/csr_isa_pkg.sv
common/csr_ctl_pkg.sv
design/csr_access.sv
design/csr_file.sv
trap/csr_trap.sv
hpm/csr_hpm.sv
design/csr_top.sv
dv/csr_assertions.sv
dv/csr_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --timescale 1ns/1ps --top-module csr_tb -f list.f
	./obj_dir/Vcsr_tb > sim.log 2>&1 || echo "** FAIL **" >> sim.log
	cat sim.log
	! grep -qF "** FAIL **" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/csr_tb.sv
`timescale 1ns/1ps
`include "csr_config.svh"

/* CSR unit testbench
   reads one vector per clock from the tests file and checks outputs before the next edge */
module csr_tb;
  import csr_isa_pkg::*;
  import csr_ctl_pkg::*;

  localparam int unsigned RST_CYCLES  = 10;
  localparam int unsigned RST_TIMEOUT = 50;    // cycles allowed for reset release
  localparam int unsigned MAX_VECTORS = 1000;  // guard against a runaway file

  // DUT inputs
  logic                 clk;
  logic                 rst;
  ctl_csr_t             csr_ctl;
  logic [`CSR_XLEN-1:0] csr_wdt;
  ctl_priv_t            priv;
  logic                 trap;
  logic [`CSR_XLEN-1:0] epc_in;
  hpm_event_t           ev;

  // DUT outputs
  logic [`CSR_XLEN-1:0] csr_rdt;
  logic                 csr_ill;
  logic [`CSR_XLEN-1:0] epc_out;
  logic [`CSR_XLEN-1:0] tvec;
  level_t               level;

  // stimulus and expected values of one vector
  logic [31:0] t_ren, t_wen, t_op, t_msk, t_imm, t_adr, t_wdt, t_trap, t_typ, t_epc, t_ev;
  logic [31:0] x_rdt, x_ill, x_lvl, x_tvec, x_epc;

  int    fd;
  int    code;
  int    lno;      // file line number for error lines
  int    vectors;
  int    waited;
  bit    done;
  string line;

  csr_top DUT (
    .clk       (clk),
    .rst       (rst),
    .csr_ctl_i (csr_ctl),
    .csr_wdt_i (csr_wdt),
    .csr_rdt_o (csr_rdt),
    .csr_ill_o (csr_ill),
    .priv_i    (priv),
    .trap_i    (trap),
    .epc_i     (epc_in),
    .epc_o     (epc_out),
    .tvec_o    (tvec),
    .event_i   (ev),
    .level_o   (level)
  );

  always #20 clk = ~clk;  // 40 ns period

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "run stopped");
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR %0d ns: line %0d %s is %h, expected %h",
                          $time, lno, name, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // reset and idle inputs
  ////////////////////////////////////////

  initial begin
    clk     = 1'b0;
    rst     = 1'b1;
    csr_ctl = '0;
    csr_wdt = '0;
    priv    = '0;
    trap    = 1'b0;
    epc_in  = '0;
    ev      = '0;
    repeat (RST_CYCLES) @(posedge clk);
    #2 rst = 1'b0;  // released off the edge
  end

  ////////////////////////////////////////
  // vector loop
  ////////////////////////////////////////

  initial begin
    lno     = 0;
    vectors = 0;
    waited  = 0;
    done    = 1'b0;
    fd = $fopen("dv/csr_tests.txt", "r");
    if (fd == 0) abort_run("could not open the test file dv/csr_tests.txt");
    @(posedge clk);
    while (rst) begin
      @(posedge clk);
      waited++;
      if (waited > RST_TIMEOUT) abort_run("reset was never released");
    end
    while (!done) begin
      code = $fgets(line, fd);
      lno++;
      if (code == 0) begin
        done = 1'b1;
      end else if (line.len() > 1 && line[0] != "#") begin  // skip comments and blanks
        if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    t_ren, t_wen, t_op, t_msk, t_imm, t_adr, t_wdt, t_trap, t_typ,
                    t_epc, t_ev, x_rdt, x_ill, x_lvl, x_tvec, x_epc) != 16) begin
          abort_run($sformatf("test file line %0d could not be parsed", lno));
        end
        #2;                                  // drive after the edge
        csr_ctl.ren = t_ren[0];
        csr_ctl.wen = t_wen[0];
        csr_ctl.op  = csr_op_e'(t_op[1:0]);
        csr_ctl.msk = csr_msk_e'(t_msk[0]);
        csr_ctl.imm = t_imm[4:0];
        csr_ctl.adr = csr_adr_t'(t_adr[11:0]);
        csr_wdt     = t_wdt;
        trap        = t_trap[0];
        priv.typ    = priv_typ_e'(t_typ[1:0]);
        epc_in      = t_epc;
        ev          = hpm_event_t'(t_ev[3:0]);
        #36;                                 // sample 2 ns before next edge
        compare("csr_rdt_o", csr_rdt, x_rdt);
        compare("csr_ill_o", 32'(csr_ill), x_ill);
        compare("level_o", 32'(level), x_lvl);
        compare("tvec_o", tvec, x_tvec);
        compare("epc_o", epc_out, x_epc);
        @(posedge clk);
        vectors++;
        if (vectors > MAX_VECTORS) abort_run("test file holds too many vectors");
      end
    end
    $fclose(fd);
    if (vectors == 0) begin
      abort_run("the test file held no vectors");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

//--- dv/csr_assertions.sv
`timescale 1ns/1ps
`include "csr_config.svh"

/* CSR unit assertions
   read gating on illegal access, level encoding, epc capture on trap */
module csr_assertions (
  input logic                 clk,
  input logic                 rst,
  input logic [`CSR_XLEN-1:0] rdt_i,
  input logic                 ill_i,
  input csr_isa_pkg::level_t  level_i,
  input logic                 trap_i,
  input logic [`CSR_XLEN-1:0] trap_epc_i,  // pc of trapping instruction
  input logic [`CSR_XLEN-1:0] epc_i        // epc seen by the core
);
  import csr_isa_pkg::*;

  // no data leaks on an illegal access
  ill_zero_a : assert property (@(posedge clk) disable iff (rst)
    ill_i |-> rdt_i == '0) else $error("read data not zero on illegal access");

  level_a : assert property (@(posedge clk) disable iff (rst)
    level_i != LVL_R) else $error("reserved privilege level reached");

  // epc follows one cycle after the trap
  epc_a : assert property (@(posedge clk) disable iff (rst)
    trap_i |=> epc_i == $past(trap_epc_i)) else $error("trap epc not captured");

endmodule

bind csr_top csr_assertions u_assertions (
  .clk        (clk),
  .rst        (rst),
  .rdt_i      (csr_rdt_o),
  .ill_i      (csr_ill_o),
  .level_i    (level_o),
  .trap_i     (trap_i),
  .trap_epc_i (epc_i),
  .epc_i      (epc_o)
);

//--- design/csr_top.sv
`timescale 1ns/1ps
`include "csr_config.svh"

/* CSR unit top level
   access checker, register file, trap unit and performance monitor */
module csr_top (
  input  logic                      clk,
  input  logic                      rst,
  input  csr_ctl_pkg::ctl_csr_t     csr_ctl_i,
  input  logic [`CSR_XLEN-1:0]      csr_wdt_i,
  output logic [`CSR_XLEN-1:0]      csr_rdt_o,
  output logic                      csr_ill_o,
  input  csr_ctl_pkg::ctl_priv_t    priv_i,
  input  logic                      trap_i,
  input  logic [`CSR_XLEN-1:0]      epc_i,
  output logic [`CSR_XLEN-1:0]      epc_o,
  output logic [`CSR_XLEN-1:0]      tvec_o,
  input  csr_ctl_pkg::hpm_event_t   event_i,
  output csr_isa_pkg::level_t       level_o
);
  import csr_isa_pkg::*;
  import csr_ctl_pkg::*;

  csr_sel_t                                sel;
  logic                                    wen;
  logic [`CSR_XLEN-1:0]                    wdt;
  logic [`CSR_XLEN-1:0]                    rdt;        // raw read back to checker
  trap_regs_t                              trap_regs;
  hpm_cnt_t                                counters;
  logic [`CSR_XLEN-1:0]                    mcountinhibit;
  logic [`CSR_HPM_NUM-1:0][`CSR_XLEN-1:0]  mhpmevent;
  tvec_u                                   mtvec;
  tvec_u                                   stvec;
  level_t                                  level;

  csr_access u_access (
    .csr_ctl_i (csr_ctl_i),
    .csr_wdt_i (csr_wdt_i),
    .level_i   (level),
    .trap_i    (trap_i),
    .rdt_i     (rdt),
    .sel_o     (sel),
    .wen_o     (wen),
    .wdt_o     (wdt),
    .csr_rdt_o (csr_rdt_o),
    .csr_ill_o (csr_ill_o)
  );

  csr_file u_file (
    .clk             (clk),
    .rst             (rst),
    .sel_i           (sel),
    .wen_i           (wen),
    .wdt_i           (wdt),
    .trap_regs_i     (trap_regs),
    .counters_i      (counters),
    .rdt_o           (rdt),
    .mcountinhibit_o (mcountinhibit),
    .mhpmevent_o     (mhpmevent),
    .mtvec_o         (mtvec),
    .stvec_o         (stvec)
  );

  csr_trap u_trap (
    .clk         (clk),
    .rst         (rst),
    .priv_i      (priv_i),
    .trap_i      (trap_i),
    .epc_i       (epc_i),
    .sel_i       (sel),
    .wen_i       (wen),
    .wdt_i       (wdt),
    .mtvec_i     (mtvec),
    .stvec_i     (stvec),
    .level_o     (level),
    .trap_regs_o (trap_regs),
    .tvec_o      (tvec_o),
    .epc_o       (epc_o)
  );

  csr_hpm u_hpm (
    .clk             (clk),
    .rst             (rst),
    .event_i         (event_i),
    .mcountinhibit_i (mcountinhibit),
    .mhpmevent_i     (mhpmevent),
    .sel_i           (sel),
    .wen_i           (wen),
    .wdt_i           (wdt),
    .counters_o      (counters)
  );

  assign level_o = level;

endmodule

//--- hpm/csr_hpm.sv
`timescale 1ns/1ps
`include "csr_config.svh"

/* performance monitor
   mcycle, minstret and event counters under mcountinhibit */
module csr_hpm (
  input  logic                                    clk,
  input  logic                                    rst,
  input  csr_ctl_pkg::hpm_event_t                 event_i,
  input  logic [`CSR_XLEN-1:0]                    mcountinhibit_i,
  input  logic [`CSR_HPM_NUM-1:0][`CSR_XLEN-1:0]  mhpmevent_i,
  input  csr_ctl_pkg::csr_sel_t                   sel_i,
  input  logic                                    wen_i,
  input  logic [`CSR_XLEN-1:0]                    wdt_i,
  output csr_ctl_pkg::hpm_cnt_t                   counters_o
);
  import csr_isa_pkg::*;
  import csr_ctl_pkg::*;

  localparam int unsigned XLEN = `CSR_XLEN;

  hpm_cnt_t                cnt;
  logic                    cy_inc;
  logic                    ir_inc;
  logic [`CSR_HPM_NUM-1:0] hpm_inc;

  // a write beats the increment
  function automatic logic [XLEN-1:0] cnt_next (
    input logic [XLEN-1:0] val,
    input logic            wr,
    input logic            inc
  );
    if (wr) return wdt_i;
    return inc ? val + 1'b1 : val;
  endfunction

  assign cy_inc = event_i.cycle   & ~mcountinhibit_i[MCI_CY];
  assign ir_inc = event_i.instret & ~mcountinhibit_i[MCI_IR];

  // any selected event bit counts
  always_comb begin
    for (int i = 0; i < `CSR_HPM_NUM; i++) begin
      hpm_inc[i] = |(mhpmevent_i[i] & XLEN'(event_i)) & ~mcountinhibit_i[HPM_BASE + i];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt <= '0;
    end else begin
      cnt.mcycle   <= cnt_next(cnt.mcycle,   wen_i & sel_i.mcycle,   cy_inc);
      cnt.minstret <= cnt_next(cnt.minstret, wen_i & sel_i.minstret, ir_inc);
      for (int i = 0; i < `CSR_HPM_NUM; i++) begin
        cnt.mhpmcounter[i] <= cnt_next(cnt.mhpmcounter[i],
                                       wen_i & sel_i.mhpmcounter[i], hpm_inc[i]);
      end
    end
  end

  assign counters_o = cnt;

endmodule

//--- trap/csr_trap.sv
`timescale 1ns/1ps
`include "csr_config.svh"

/* trap unit
   privilege level, ECALL/EBREAK cause, medeleg delegation and trap vector */
module csr_trap (
  input  logic                       clk,
  input  logic                       rst,
  input  csr_ctl_pkg::ctl_priv_t     priv_i,      // ECALL/EBREAK type
  input  logic                       trap_i,
  input  logic [`CSR_XLEN-1:0]       epc_i,       // pc of trapping instruction
  input  csr_ctl_pkg::csr_sel_t      sel_i,
  input  logic                       wen_i,
  input  logic [`CSR_XLEN-1:0]       wdt_i,
  input  csr_isa_pkg::tvec_u         mtvec_i,
  input  csr_isa_pkg::tvec_u         stvec_i,
  output csr_isa_pkg::level_t        level_o,
  output csr_ctl_pkg::trap_regs_t    trap_regs_o,
  output logic [`CSR_XLEN-1:0]       tvec_o,
  output logic [`CSR_XLEN-1:0]       epc_o
);
  import csr_isa_pkg::*;
  import csr_ctl_pkg::*;

  level_t     level;
  trap_regs_t regs;
  cause_t     cause;  // cause of trap in this cycle
  logic       deleg;  // send trap to S level

  ////////////////////////////////////////
  // cause and delegation
  ////////////////////////////////////////

  always_comb begin
    cause = '0;                      // no interrupts, bit 31 stays low
    unique case (priv_i.typ)
      PRIV_EBREAK: cause.Code = CAUSE_EBREAK;
      PRIV_ECALL : begin
        unique case (level)          // 8 + level
          LVL_U  : cause.Code = CAUSE_UCALL;
          LVL_S  : cause.Code = CAUSE_SCALL;
          LVL_M  : cause.Code = CAUSE_MCALL;
          default: cause.Code = CAUSE_UCALL + 'd2;  // reserved code 10
        endcase
      end
      PRIV_NONE  : cause.Code = '0;
      default    : cause.Code = '0;
    endcase
  end

  assign deleg = regs.medeleg[cause.Code[4:0]];

  ////////////////////////////////////////
  // level and trap registers
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      level <= LVL_M;                // start in machine mode
      regs  <= '0;
    end else if (trap_i) begin
      if (deleg) begin
        level       <= LVL_S;
        regs.sepc   <= epc_i;
        regs.scause <= cause;
      end else begin
        level       <= LVL_M;
        regs.mepc   <= epc_i;
        regs.mcause <= cause;
      end
    end else if (wen_i) begin        // Zicsr writes
      if (sel_i.medeleg) regs.medeleg <= wdt_i;
      if (sel_i.mepc)    regs.mepc    <= wdt_i;
      if (sel_i.mcause)  regs.mcause  <= wdt_i;
      if (sel_i.sepc)    regs.sepc    <= wdt_i;
      if (sel_i.scause)  regs.scause  <= wdt_i;
    end
  end

  ////////////////////////////////////////
  // trap vector and return pc
  ////////////////////////////////////////

  function automatic logic [`CSR_XLEN-1:0] tvec_f (
    input tvec_u  tv,
    input cause_t cs
  );
    logic [`CSR_XLEN-1:0] base;
    base = {tv.f.BASE, 2'b00};       // BASE times 4
    if (tv.f.MODE == TVEC_VECTORED) begin
      return base + {cs.Code[`CSR_XLEN-4:0], 2'b00};  // plus 4 x Code
    end
    return base;                     // direct, reserved modes too
  endfunction

  always_comb begin
    if (level == LVL_S) begin
      tvec_o = tvec_f(stvec_i, regs.scause);
      epc_o  = regs.sepc;
    end else begin
      tvec_o = tvec_f(mtvec_i, regs.mcause);  // M level
      epc_o  = regs.mepc;
    end
  end

  assign level_o     = level;
  assign trap_regs_o = regs;

endmodule

//--- design/csr_file.sv
`timescale 1ns/1ps
`include "csr_config.svh"

/* plain CSR storage
   trap vectors, scratch, counter control, and the read-data multiplexer */
module csr_file (
  input  logic                                    clk,
  input  logic                                    rst,
  input  csr_ctl_pkg::csr_sel_t                   sel_i,
  input  logic                                    wen_i,
  input  logic [`CSR_XLEN-1:0]                    wdt_i,
  input  csr_ctl_pkg::trap_regs_t                 trap_regs_i,      // from trap unit
  input  csr_ctl_pkg::hpm_cnt_t                   counters_i,       // from hpm
  output logic [`CSR_XLEN-1:0]                    rdt_o,
  output logic [`CSR_XLEN-1:0]                    mcountinhibit_o,
  output logic [`CSR_HPM_NUM-1:0][`CSR_XLEN-1:0]  mhpmevent_o,
  output csr_isa_pkg::tvec_u                      mtvec_o,
  output csr_isa_pkg::tvec_u                      stvec_o
);
  import csr_isa_pkg::*;

  tvec_u                                   mtvec;
  tvec_u                                   stvec;
  logic [`CSR_XLEN-1:0]                    mscratch;
  logic [`CSR_XLEN-1:0]                    mcountinhibit;
  logic [`CSR_HPM_NUM-1:0][`CSR_XLEN-1:0]  mhpmevent;

  // Zicsr writes to locally owned registers
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mtvec.raw     <= `CSR_MTVEC_RST;
      stvec.raw     <= '0;
      mscratch      <= '0;
      mcountinhibit <= '0;
      mhpmevent     <= '0;
    end else if (wen_i) begin
      if (sel_i.mtvec)         mtvec.raw     <= wdt_i;
      if (sel_i.stvec)         stvec.raw     <= wdt_i;
      if (sel_i.mscratch)      mscratch      <= wdt_i;
      if (sel_i.mcountinhibit) mcountinhibit <= wdt_i;
      for (int i = 0; i < `CSR_HPM_NUM; i++) begin
        if (sel_i.mhpmevent[i]) mhpmevent[i] <= wdt_i;
      end
    end
  end

  ////////////////////////////////////////
  // read mux, select is one-hot
  ////////////////////////////////////////

  always_comb begin
    rdt_o = '0;
    if (sel_i.mtvec)                 rdt_o = mtvec.raw;
    if (sel_i.stvec)                 rdt_o = stvec.raw;
    if (sel_i.mscratch)              rdt_o = mscratch;
    if (sel_i.mcountinhibit)         rdt_o = mcountinhibit;
    if (sel_i.medeleg)               rdt_o = trap_regs_i.medeleg;
    if (sel_i.mepc)                  rdt_o = trap_regs_i.mepc;
    if (sel_i.mcause)                rdt_o = trap_regs_i.mcause;
    if (sel_i.sepc)                  rdt_o = trap_regs_i.sepc;
    if (sel_i.scause)                rdt_o = trap_regs_i.scause;
    if (sel_i.mcycle | sel_i.cycle)  rdt_o = counters_i.mcycle;    // alias reads too
    if (sel_i.minstret | sel_i.instret) rdt_o = counters_i.minstret;
    for (int i = 0; i < `CSR_HPM_NUM; i++) begin
      if (sel_i.mhpmevent[i])   rdt_o = mhpmevent[i];
      if (sel_i.mhpmcounter[i]) rdt_o = counters_i.mhpmcounter[i];
    end
  end

  assign mtvec_o         = mtvec;
  assign stvec_o         = stvec;
  assign mcountinhibit_o = mcountinhibit;
  assign mhpmevent_o     = mhpmevent;

endmodule

//--- design/csr_access.sv
`timescale 1ns/1ps
`include "csr_config.svh"

/* CSR access checker
   address decode, privilege and read-only checks, read-modify-write value */
module csr_access (
  input  csr_ctl_pkg::ctl_csr_t   csr_ctl_i,  // Zicsr instruction control
  input  logic [`CSR_XLEN-1:0]    csr_wdt_i,  // rs1 value
  input  csr_isa_pkg::level_t     level_i,    // current privilege level
  input  logic                    trap_i,     // trap taken this cycle
  input  logic [`CSR_XLEN-1:0]    rdt_i,      // raw value of selected register
  output csr_ctl_pkg::csr_sel_t   sel_o,
  output logic                    wen_o,      // qualified write strobe
  output logic [`CSR_XLEN-1:0]    wdt_o,      // new register value
  output logic [`CSR_XLEN-1:0]    csr_rdt_o,  // read data to GPR
  output logic                    csr_ill_o
);
  import csr_isa_pkg::*;
  import csr_ctl_pkg::*;

  localparam int unsigned XLEN = `CSR_XLEN;

  logic            lvl_ok;  // address level reachable
  logic            ro;      // read-only segment
  logic            ill;
  logic [XLEN-1:0] msk;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  always_comb begin
    sel_o = '0;
    unique case (csr_ctl_i.adr)
      CSR_MTVEC        : sel_o.mtvec          = 1'b1;
      CSR_MSCRATCH     : sel_o.mscratch       = 1'b1;
      CSR_MEPC         : sel_o.mepc           = 1'b1;
      CSR_MCAUSE       : sel_o.mcause         = 1'b1;
      CSR_MEDELEG      : sel_o.medeleg        = 1'b1;
      CSR_MCOUNTINHIBIT: sel_o.mcountinhibit  = 1'b1;
      CSR_MHPMEVENT3   : sel_o.mhpmevent[0]   = 1'b1;
      CSR_MHPMEVENT4   : sel_o.mhpmevent[1]   = 1'b1;
      CSR_STVEC        : sel_o.stvec          = 1'b1;
      CSR_SEPC         : sel_o.sepc           = 1'b1;
      CSR_SCAUSE       : sel_o.scause         = 1'b1;
      CSR_MCYCLE       : sel_o.mcycle         = 1'b1;
      CSR_MINSTRET     : sel_o.minstret       = 1'b1;
      CSR_MHPMCOUNTER3 : sel_o.mhpmcounter[0] = 1'b1;
      CSR_MHPMCOUNTER4 : sel_o.mhpmcounter[1] = 1'b1;
      CSR_CYCLE        : sel_o.cycle          = 1'b1;
      CSR_INSTRET      : sel_o.instret        = 1'b1;
      default          : ;                            // not implemented
    endcase
    sel_o.hit = |sel_o;  // hit still zero here, so only register bits count
  end

  ////////////////////////////////////////
  // conventions check
  ////////////////////////////////////////

  assign lvl_ok = csr_ctl_i.adr.level <= level_i;
  assign ro     = csr_ctl_i.adr.perm == ACCESS_RO;

  // illegal only when an access is requested
  assign ill = (csr_ctl_i.ren | csr_ctl_i.wen) &
               (~lvl_ok | (csr_ctl_i.wen & ro) | ~sel_o.hit);

  assign csr_ill_o = ill;
  assign csr_rdt_o = (csr_ctl_i.ren & ~ill) ? rdt_i : '0;
  assign wen_o     = csr_ctl_i.wen & ~ill & ~trap_i;  // trap wins over Zicsr

  ////////////////////////////////////////
  // new value
  ////////////////////////////////////////

  assign msk = (csr_ctl_i.msk == CSR_IMM) ? XLEN'(csr_ctl_i.imm) : csr_wdt_i;

  always_comb begin
    unique case (csr_ctl_i.op)
      CSR_RW  : wdt_o = msk;            // write mask
      CSR_SET : wdt_o = rdt_i | msk;    // set mask bits
      CSR_CLR : wdt_o = rdt_i & ~msk;   // clear mask bits
      CSR_NONE: wdt_o = rdt_i;          // keep
      default : wdt_o = rdt_i;
    endcase
  end

endmodule

//--- common/csr_ctl_pkg.sv
/* CSR unit control structs
   instruction and privileged control, events, decoded select, block state */

`include "csr_config.svh"

package csr_ctl_pkg;

  typedef enum logic [1:0] {
    CSR_NONE = 2'd0,
    CSR_RW   = 2'd1,
    CSR_SET  = 2'd2,
    CSR_CLR  = 2'd3
  } csr_op_e;

  typedef enum logic {
    CSR_REG = 1'b0,  // mask from rs1
    CSR_IMM = 1'b1   // mask from uimm
  } csr_msk_e;

  // Zicsr instruction control
  typedef struct packed {
    logic                  ren;
    logic                  wen;
    csr_op_e               op;
    csr_msk_e              msk;
    logic [4:0]            imm;
    csr_isa_pkg::csr_adr_t adr;
  } ctl_csr_t;

  typedef enum logic [1:0] {
    PRIV_NONE   = 2'd0,
    PRIV_ECALL  = 2'd1,
    PRIV_EBREAK = 2'd2
  } priv_typ_e;

  typedef struct packed {
    priv_typ_e typ;
  } ctl_priv_t;

  // event vector, bit i matches mhpmevent bit i
  typedef struct packed {
    logic load;
    logic branch;
    logic instret;
    logic cycle;    // bit 0
  } hpm_event_t;

  // one-hot register select
  typedef struct packed {
    logic                    mtvec;
    logic                    mscratch;
    logic                    mepc;
    logic                    mcause;
    logic                    medeleg;
    logic                    mcountinhibit;
    logic [`CSR_HPM_NUM-1:0] mhpmevent;
    logic                    stvec;
    logic                    sepc;
    logic                    scause;
    logic                    mcycle;
    logic                    minstret;
    logic [`CSR_HPM_NUM-1:0] mhpmcounter;
    logic                    cycle;
    logic                    instret;
    logic                    hit;       // address implemented
  } csr_sel_t;

  // registers owned by the trap unit
  typedef struct packed {
    logic [`CSR_XLEN-1:0] medeleg;
    logic [`CSR_XLEN-1:0] mepc;
    csr_isa_pkg::cause_t  mcause;
    logic [`CSR_XLEN-1:0] sepc;
    csr_isa_pkg::cause_t  scause;
  } trap_regs_t;

  // registers owned by the performance monitor
  typedef struct packed {
    logic [`CSR_XLEN-1:0]                    mcycle;
    logic [`CSR_XLEN-1:0]                    minstret;
    logic [`CSR_HPM_NUM-1:0][`CSR_XLEN-1:0]  mhpmcounter;
  } hpm_cnt_t;

endpackage

//--- common/csr_isa_pkg.sv
/* RV32 CSR architectural types
   privilege levels, address fields, register numbers, causes and trap vector */

`include "csr_config.svh"

package csr_isa_pkg;

  // privilege level
  typedef enum logic [1:0] {
    LVL_U = 2'b00,  // user
    LVL_S = 2'b01,  // supervisor
    LVL_R = 2'b10,  // reserved (hypervisor slot)
    LVL_M = 2'b11   // machine
  } level_t;

  // address fields per the CSR mapping conventions
  typedef struct packed {
    logic [1:0] perm;   // 2'b11 marks read-only
    level_t     level;  // lowest level allowed to access
    logic [7:0] idx;
  } csr_adr_t;

  localparam logic [1:0] ACCESS_RO = 2'b11;

  ////////////////////////////////////////
  // register numbers
  ////////////////////////////////////////

  localparam logic [11:0] CSR_MTVEC         = 12'h305;
  localparam logic [11:0] CSR_MSCRATCH      = 12'h340;
  localparam logic [11:0] CSR_MEPC          = 12'h341;
  localparam logic [11:0] CSR_MCAUSE        = 12'h342;
  localparam logic [11:0] CSR_MEDELEG       = 12'h302;
  localparam logic [11:0] CSR_MCOUNTINHIBIT = 12'h320;
  localparam logic [11:0] CSR_MHPMEVENT3    = 12'h323;
  localparam logic [11:0] CSR_MHPMEVENT4    = 12'h324;
  localparam logic [11:0] CSR_STVEC         = 12'h105;
  localparam logic [11:0] CSR_SEPC          = 12'h141;
  localparam logic [11:0] CSR_SCAUSE        = 12'h142;
  localparam logic [11:0] CSR_MCYCLE        = 12'hB00;
  localparam logic [11:0] CSR_MINSTRET      = 12'hB02;
  localparam logic [11:0] CSR_MHPMCOUNTER3  = 12'hB03;
  localparam logic [11:0] CSR_MHPMCOUNTER4  = 12'hB04;
  localparam logic [11:0] CSR_CYCLE         = 12'hC00;  // user alias of mcycle
  localparam logic [11:0] CSR_INSTRET       = 12'hC02;  // user alias of minstret

  // mcountinhibit bit positions
  localparam int unsigned MCI_CY   = 0;
  localparam int unsigned MCI_IR   = 2;
  localparam int unsigned HPM_BASE = 3;  // first hpm counter index

  ////////////////////////////////////////
  // trap cause and vector
  ////////////////////////////////////////

  typedef struct packed {
    logic                   Interrupt;
    logic [`CSR_XLEN-2:0]   Code;
  } cause_t;

  localparam logic [`CSR_XLEN-2:0] CAUSE_EBREAK = 'd3;
  localparam logic [`CSR_XLEN-2:0] CAUSE_UCALL  = 'd8;
  localparam logic [`CSR_XLEN-2:0] CAUSE_SCALL  = 'd9;
  localparam logic [`CSR_XLEN-2:0] CAUSE_MCALL  = 'd11;

  typedef enum logic [1:0] {
    TVEC_DIRECT   = 2'd0,
    TVEC_VECTORED = 2'd1
  } tvec_mode_e;

  // xtvec seen as a plain word or as BASE/MODE
  typedef union packed {
    logic [`CSR_XLEN-1:0] raw;
    struct packed {
      logic [`CSR_XLEN-3:0] BASE;
      tvec_mode_e           MODE;
    } f;
  } tvec_u;

endpackage

//--- common/csr_config.svh
/* CSR unit build parameters
   data width, mtvec reset value and number of event counters */

`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// data path width
`define CSR_XLEN 32

// trap vector after reset
`define CSR_MTVEC_RST 32'h0000_0100

// implemented hpm counters, indexes 3 and up
`define CSR_HPM_NUM 2

`endif
